//--- common/rename_defs.svh
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Architectural integer registers visible to software.
`define RN_NUM_GPRS 32

// Physical registers shared by the speculative and retirement maps.
`define RN_NUM_PREGS 64

// Reorder buffer entries; ROB ids wrap at this count.
`define RN_ROB_DEPTH 16

`endif

//--- common/rename_pkg.sv
`default_nettype none

`include "rename_defs.svh"

package rename_pkg;

    typedef logic [$clog2(`RN_NUM_GPRS)-1:0]  t_gpr_id;
    typedef logic [$clog2(`RN_NUM_PREGS)-1:0] t_preg_id;
    typedef logic [$clog2(`RN_ROB_DEPTH)-1:0] t_rob_id;

    typedef struct packed {
        logic    dst_vld;
        t_gpr_id dst;
        logic    src1_vld;
        t_gpr_id src1;
        logic    src2_vld;
        t_gpr_id src2;
        logic [5:0] tag;     // Opaque to rename, carried through to dispatch.
    } t_uop;

    typedef struct packed {
        t_preg_id pdst;
        t_preg_id pdst_old;  // Freed when this micro-op retires.
        t_preg_id psrc1;
        logic     psrc1_pend;
        t_preg_id psrc2;
        logic     psrc2_pend;
        t_rob_id  robid;
    } t_rename_pkt;

    typedef struct packed {
        t_uop        uop;
        t_rename_pkt rename;
    } t_rn_skid_pkt;

endpackage

`default_nettype wire

//--- rename/rename_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module rename_map (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 nuke,
    input  logic                 alloc,
    input  rename_pkg::t_gpr_id  dst,
    input  rename_pkg::t_gpr_id  src1,
    input  rename_pkg::t_gpr_id  src2,
    input  logic                 wb_valid,
    input  rename_pkg::t_preg_id wb_preg,
    input  logic                 retire_valid,
    input  rename_pkg::t_gpr_id  retire_gpr,
    input  rename_pkg::t_preg_id retire_pdst,
    input  rename_pkg::t_preg_id retire_pdst_old,
    output logic                 free_avail,
    output rename_pkg::t_preg_id pdst,
    output rename_pkg::t_preg_id pdst_old,
    output rename_pkg::t_preg_id psrc1,
    output rename_pkg::t_preg_id psrc2,
    output logic                 psrc1_pend,
    output logic                 psrc2_pend
);
    import rename_pkg::*;

    localparam logic [`RN_NUM_PREGS-1:0] INIT_FREE =
        {{(`RN_NUM_PREGS-`RN_NUM_GPRS){1'b1}}, {`RN_NUM_GPRS{1'b0}}};

    t_preg_id                 spec_map    [`RN_NUM_GPRS];
    t_preg_id                 ret_map     [`RN_NUM_GPRS];
    t_preg_id                 ret_map_nxt [`RN_NUM_GPRS];
    logic [`RN_NUM_PREGS-1:0] pend;
    logic [`RN_NUM_PREGS-1:0] free_vec;
    logic [`RN_NUM_PREGS-1:0] free_nxt;
    logic [`RN_NUM_PREGS-1:0] in_use;
    logic [`RN_NUM_PREGS-1:0] in_use_nxt;
    t_preg_id                 alloc_preg;
    t_preg_id                 src1_map;
    t_preg_id                 src2_map;

    assign free_avail = |free_vec;
    assign src1_map   = spec_map[src1];
    assign src2_map   = spec_map[src2];

    always_comb begin
        alloc_preg = '0;
        for (int i = `RN_NUM_PREGS-1; i >= 0; i--) begin
            if (free_vec[i]) begin
                alloc_preg = t_preg_id'(i);  // Lowest free index wins.
            end
        end
    end

    // Retirement state after this cycle's retire, so a nuke in the same cycle sees it.
    always_comb begin
        ret_map_nxt = ret_map;
        in_use_nxt  = in_use;
        if (retire_valid) begin
            ret_map_nxt[retire_gpr]     = retire_pdst;
            in_use_nxt[retire_pdst_old] = 1'b0;
            in_use_nxt[retire_pdst]     = 1'b1;
        end
    end

    always_comb begin
        free_nxt = free_vec;
        if (retire_valid) begin
            free_nxt[retire_pdst_old] = 1'b1;
        end
        if (alloc) begin
            free_nxt[alloc_preg] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RN_NUM_GPRS; i++) begin
                spec_map[i] <= t_preg_id'(i);
                ret_map[i]  <= t_preg_id'(i);
            end
            pend     <= '0;
            free_vec <= INIT_FREE;
            in_use   <= ~INIT_FREE;
        end else begin
            ret_map <= ret_map_nxt;
            in_use  <= in_use_nxt;
            if (nuke) begin
                spec_map <= ret_map_nxt;
                free_vec <= ~in_use_nxt;  // Everything the retired state does not hold.
                pend     <= '0;
            end else begin
                free_vec <= free_nxt;
                if (alloc) begin
                    spec_map[dst]    <= alloc_preg;
                    pend[alloc_preg] <= 1'b1;
                end
                if (wb_valid) begin
                    pend[wb_preg] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        pdst       <= alloc_preg;
        pdst_old   <= spec_map[dst];
        psrc1      <= src1_map;
        psrc2      <= src2_map;
        psrc1_pend <= pend[src1_map] & ~(wb_valid && wb_preg == src1_map);
        psrc2_pend <= pend[src2_map] & ~(wb_valid && wb_preg == src2_map);
    end

    a_retire_not_free: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> !free_vec[retire_pdst_old]);

    a_alloc_has_free: assert property (@(posedge clk) disable iff (rst)
        alloc |-> free_avail);

endmodule

`default_nettype wire

//--- rename/rename_skid.sv
`timescale 1ns/1ps
`default_nettype none

module rename_skid #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic in_valid,
    input  T     in_data,
    input  logic hold,
    output logic out_valid,
    output T     out_data,
    output logic empty
);

    T           mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       full;
    logic       push;
    logic       pop;

    assign empty = (count == 2'd0);
    assign full  = (count == 2'd2);

    // An empty, non-held buffer passes the input straight through.
    assign push      = in_valid & (~empty | hold);
    assign pop       = ~empty & ~hold;
    assign out_valid = empty ? in_valid : 1'b1;
    assign out_data  = empty ? in_data : mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !full);

endmodule

`default_nettype wire

//--- rename/rename_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rename_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   nuke,
    input  logic                   in_valid,
    input  rename_pkg::t_uop       in_uop,
    output logic                   in_ready,
    input  logic                   rob_ready,
    input  rename_pkg::t_rob_id    next_robid,
    output logic                   rob_alloc,
    input  logic                   wb_valid,
    input  rename_pkg::t_preg_id   wb_preg,
    input  logic                   retire_valid,
    input  rename_pkg::t_gpr_id    retire_gpr,
    input  rename_pkg::t_preg_id   retire_pdst,
    input  rename_pkg::t_preg_id   retire_pdst_old,
    output logic                   out_valid,
    input  logic                   out_ready,
    output rename_pkg::t_uop       out_uop,
    output rename_pkg::t_rename_pkt out_rename
);
    import rename_pkg::*;

    logic         accept_rn0;
    logic         free_avail;
    logic         skid_empty;
    logic         valid_rn1;
    t_uop         uop_rn1;
    t_rob_id      robid_rn1;
    t_preg_id     pdst_rn1;
    t_preg_id     pdst_old_rn1;
    t_preg_id     psrc1_rn1;
    t_preg_id     psrc2_rn1;
    logic         psrc1_pend_rn1;
    logic         psrc2_pend_rn1;
    t_rn_skid_pkt skid_in;
    t_rn_skid_pkt skid_out;

    assign in_ready   = free_avail & rob_ready & skid_empty;
    assign accept_rn0 = in_valid & in_ready & ~nuke;
    assign rob_alloc  = accept_rn0;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_rn1 <= 1'b0;
        end else begin
            valid_rn1 <= accept_rn0;  // A nuke blocks accept, so rn1 empties too.
        end
    end

    always_ff @(posedge clk) begin
        uop_rn1   <= in_uop;
        robid_rn1 <= next_robid;
    end

    rename_map map0 (
        .clk             (clk),
        .rst             (rst),
        .nuke            (nuke),
        .alloc           (accept_rn0 & in_uop.dst_vld),
        .dst             (in_uop.dst),
        .src1            (in_uop.src1),
        .src2            (in_uop.src2),
        .wb_valid        (wb_valid),
        .wb_preg         (wb_preg),
        .retire_valid    (retire_valid),
        .retire_gpr      (retire_gpr),
        .retire_pdst     (retire_pdst),
        .retire_pdst_old (retire_pdst_old),
        .free_avail      (free_avail),
        .pdst            (pdst_rn1),
        .pdst_old        (pdst_old_rn1),
        .psrc1           (psrc1_rn1),
        .psrc2           (psrc2_rn1),
        .psrc1_pend      (psrc1_pend_rn1),
        .psrc2_pend      (psrc2_pend_rn1)
    );

    assign skid_in.uop               = uop_rn1;
    assign skid_in.rename.pdst       = uop_rn1.dst_vld ? pdst_rn1 : '0;
    assign skid_in.rename.pdst_old   = uop_rn1.dst_vld ? pdst_old_rn1 : '0;
    assign skid_in.rename.psrc1      = psrc1_rn1;
    assign skid_in.rename.psrc1_pend = psrc1_pend_rn1;
    assign skid_in.rename.psrc2      = psrc2_rn1;
    assign skid_in.rename.psrc2_pend = psrc2_pend_rn1;
    assign skid_in.rename.robid      = robid_rn1;

    rename_skid #(.T(t_rn_skid_pkt)) skid0 (
        .clk       (clk),
        .rst       (rst),
        .flush     (nuke),
        .in_valid  (valid_rn1 & ~nuke),
        .in_data   (skid_in),
        .hold      (~out_ready),
        .out_valid (out_valid),
        .out_data  (skid_out),
        .empty     (skid_empty)
    );

    assign out_uop    = skid_out.uop;
    assign out_rename = skid_out.rename;

endmodule

`default_nettype wire

//--- design/rob_credit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module rob_credit (
    input  logic                clk,
    input  logic                rst,
    input  logic                nuke,
    input  logic                alloc,
    input  logic                retire,
    output rename_pkg::t_rob_id next_robid,
    output logic                rob_ready
);
    import rename_pkg::*;

    localparam int CNT_W = $clog2(`RN_ROB_DEPTH) + 1;

    t_rob_id          alloc_ptr;
    t_rob_id          retire_ptr;
    t_rob_id          retire_ptr_nxt;
    logic [CNT_W-1:0] count;

    assign retire_ptr_nxt = retire ? retire_ptr + 1'b1 : retire_ptr;
    assign next_robid     = alloc_ptr;
    assign rob_ready      = (count < CNT_W'(`RN_ROB_DEPTH));

    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_ptr  <= '0;
            retire_ptr <= '0;
            count      <= '0;
        end else begin
            retire_ptr <= retire_ptr_nxt;
            if (nuke) begin
                alloc_ptr <= retire_ptr_nxt;  // Rewind past everything in flight.
                count     <= '0;
            end else begin
                if (alloc) begin
                    alloc_ptr <= alloc_ptr + 1'b1;
                end
                count <= count + CNT_W'(alloc) - CNT_W'(retire);
            end
        end
    end

    a_retire_in_flight: assert property (@(posedge clk) disable iff (rst)
        retire |-> count != '0);

endmodule

`default_nettype wire

//--- design/rename_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rename_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    nuke,
    input  logic                    in_valid,
    input  rename_pkg::t_uop        in_uop,
    output logic                    in_ready,
    output logic                    out_valid,
    input  logic                    out_ready,
    output rename_pkg::t_uop        out_uop,
    output rename_pkg::t_rename_pkt out_rename,
    input  logic                    wb_valid,
    input  rename_pkg::t_preg_id    wb_preg,
    input  logic                    retire_valid,
    input  rename_pkg::t_gpr_id     retire_gpr,
    input  rename_pkg::t_preg_id    retire_pdst,
    input  rename_pkg::t_preg_id    retire_pdst_old
);
    import rename_pkg::*;

    logic    rob_alloc;
    logic    rob_ready;
    t_rob_id next_robid;

    rename_stage stage0 (
        .clk             (clk),
        .rst             (rst),
        .nuke            (nuke),
        .in_valid        (in_valid),
        .in_uop          (in_uop),
        .in_ready        (in_ready),
        .rob_ready       (rob_ready),
        .next_robid      (next_robid),
        .rob_alloc       (rob_alloc),
        .wb_valid        (wb_valid),
        .wb_preg         (wb_preg),
        .retire_valid    (retire_valid),
        .retire_gpr      (retire_gpr),
        .retire_pdst     (retire_pdst),
        .retire_pdst_old (retire_pdst_old),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_uop         (out_uop),
        .out_rename      (out_rename)
    );

    rob_credit credit0 (
        .clk        (clk),
        .rst        (rst),
        .nuke       (nuke),
        .alloc      (rob_alloc),
        .retire     (retire_valid),  // One credit returns per retired entry.
        .next_robid (next_robid),
        .rob_ready  (rob_ready)
    );

endmodule

`default_nettype wire

//--- tests/rename_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module rename_unit_tb;
    import rename_pkg::*;

    localparam int K_REN   = 0;
    localparam int K_WB    = 1;
    localparam int K_RET   = 2;
    localparam int K_STALL = 3;
    localparam int K_NUKE  = 4;
    localparam int K_IDLE  = 5;

    logic        clk;
    logic        rst;
    logic        nuke;
    logic        in_valid;
    t_uop        in_uop;
    logic        in_ready;
    logic        out_valid;
    logic        out_ready;
    t_uop        out_uop;
    t_rename_pkt out_rename;
    logic        wb_valid;
    t_preg_id    wb_preg;
    logic        retire_valid;
    t_gpr_id     retire_gpr;
    t_preg_id    retire_pdst;
    t_preg_id    retire_pdst_old;

    // Step table, filled once at time zero.
    int       st_kind[$];
    int       st_test[$];
    int       st_n[$];
    int       st_exp[$];          // Expected in_ready level in idle steps. A value of 2 means either.
    t_uop     st_uop[$];
    logic     st_wb_en[$];
    t_preg_id st_wb_preg[$];
    string    test_name[1:6];

    // Reference model of the maps, free list and ROB pointers.
    t_preg_id                 m_spec[`RN_NUM_GPRS];
    t_preg_id                 m_ret[`RN_NUM_GPRS];
    logic [`RN_NUM_PREGS-1:0] m_pend;
    logic [`RN_NUM_PREGS-1:0] m_free;
    logic [`RN_NUM_PREGS-1:0] m_inuse;
    t_rob_id                  m_alloc_ptr;
    t_rob_id                  m_ret_ptr;
    int                       m_count;
    logic                     last_acc;
    t_rename_pkt              exp_q[$];
    t_uop                     uop_q[$];
    t_gpr_id                  rq_gpr[$];
    t_preg_id                 rq_pdst[$];
    t_preg_id                 rq_old[$];

    int n_checks;
    int n_errors;
    int cycles;
    int cycle_limit;
    int ready_low_left;

    rename_unit dut0 (
        .clk             (clk),
        .rst             (rst),
        .nuke            (nuke),
        .in_valid        (in_valid),
        .in_uop          (in_uop),
        .in_ready        (in_ready),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_uop         (out_uop),
        .out_rename      (out_rename),
        .wb_valid        (wb_valid),
        .wb_preg         (wb_preg),
        .retire_valid    (retire_valid),
        .retire_gpr      (retire_gpr),
        .retire_pdst     (retire_pdst),
        .retire_pdst_old (retire_pdst_old)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic add_step(input int kind, input int test, input logic dv, input int dst,
                            input int s1, input int s2, input logic wb_en, input int wbp,
                            input int n, input int exp);
        t_uop u;
        u.dst_vld  = dv;
        u.dst      = t_gpr_id'(dst);
        u.src1_vld = 1'b1;
        u.src1     = t_gpr_id'(s1);
        u.src2_vld = 1'b1;
        u.src2     = t_gpr_id'(s2);
        u.tag      = 6'(st_kind.size());
        st_kind.push_back(kind);
        st_test.push_back(test);
        st_n.push_back(n);
        st_exp.push_back(exp);
        st_uop.push_back(u);
        st_wb_en.push_back(wb_en);
        st_wb_preg.push_back(t_preg_id'(wbp));
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch at time %0t: %s got 0x%0h, expected 0x%0h",
                     $time, name, got, exp);
        end
    endtask

    function automatic int lowest_free();
        int r;
        r = -1;
        for (int p = 0; p < `RN_NUM_PREGS; p++) begin
            if (m_free[p] && r < 0) begin
                r = p;
            end
        end
        return r;
    endfunction

    // One clock cycle. Outputs are sampled 10 ns before the rising edge, then the model
    // takes the same edge.
    task automatic tick(input int exp_col, output logic acc);
        int          lf;
        int          skid_items;
        logic        rdy_model;
        t_rename_pkt pkt;
        out_ready = (ready_low_left == 0);
        if (ready_low_left > 0) begin
            ready_low_left--;
        end
        #10;
        lf         = lowest_free();
        skid_items = exp_q.size() - (last_acc ? 1 : 0);  // Last accept still sits in rn1.
        rdy_model  = (lf >= 0) && (m_count < `RN_ROB_DEPTH) && (skid_items == 0);
        check_field("in_ready", in_ready, rdy_model);
        if (exp_col != 2) begin
            check_field("in_ready level", in_ready, exp_col);
        end
        if (!nuke) begin
            check_field("out_valid", out_valid, exp_q.size() > 0);
            if (out_valid && out_ready && exp_q.size() > 0) begin
                check_field("uop", out_uop, uop_q[0]);
                check_field("pdst", out_rename.pdst, exp_q[0].pdst);
                check_field("pdst_old", out_rename.pdst_old, exp_q[0].pdst_old);
                check_field("psrc1", out_rename.psrc1, exp_q[0].psrc1);
                check_field("psrc1_pend", out_rename.psrc1_pend, exp_q[0].psrc1_pend);
                check_field("psrc2", out_rename.psrc2, exp_q[0].psrc2);
                check_field("psrc2_pend", out_rename.psrc2_pend, exp_q[0].psrc2_pend);
                check_field("robid", out_rename.robid, exp_q[0].robid);
                void'(exp_q.pop_front());
                void'(uop_q.pop_front());
            end
        end
        acc = in_valid && rdy_model && !nuke;
        if (acc) begin
            pkt.psrc1      = m_spec[in_uop.src1];
            pkt.psrc1_pend = m_pend[pkt.psrc1] && !(wb_valid && wb_preg == pkt.psrc1);
            pkt.psrc2      = m_spec[in_uop.src2];
            pkt.psrc2_pend = m_pend[pkt.psrc2] && !(wb_valid && wb_preg == pkt.psrc2);
            pkt.robid      = m_alloc_ptr;
            pkt.pdst       = in_uop.dst_vld ? t_preg_id'(lf) : '0;
            pkt.pdst_old   = in_uop.dst_vld ? m_spec[in_uop.dst] : '0;
            exp_q.push_back(pkt);
            uop_q.push_back(in_uop);
            rq_gpr.push_back(in_uop.dst);
            rq_pdst.push_back(pkt.pdst);
            rq_old.push_back(pkt.pdst_old);
        end
        if (retire_valid) begin
            m_ret[retire_gpr]        = retire_pdst;
            m_inuse[retire_pdst_old] = 1'b0;
            m_inuse[retire_pdst]     = 1'b1;
            m_free[retire_pdst_old]  = 1'b1;
            m_ret_ptr                = m_ret_ptr + 1'b1;
            m_count--;
        end
        if (nuke) begin
            for (int g = 0; g < `RN_NUM_GPRS; g++) begin
                m_spec[g] = m_ret[g];
            end
            m_free      = ~m_inuse;
            m_pend      = '0;
            m_alloc_ptr = m_ret_ptr;
            m_count     = 0;
            exp_q.delete();
            uop_q.delete();
            rq_gpr.delete();
            rq_pdst.delete();
            rq_old.delete();
        end else begin
            if (acc && in_uop.dst_vld) begin
                m_free[lf]          = 1'b0;
                m_spec[in_uop.dst]  = t_preg_id'(lf);
                m_pend[lf]          = 1'b1;
            end
            if (wb_valid) begin
                m_pend[wb_preg] = 1'b0;
            end
            if (acc) begin
                m_alloc_ptr = m_alloc_ptr + 1'b1;
                m_count++;
            end
        end
        last_acc = acc;
        @(posedge clk);
        @(negedge clk);
        wb_valid     = 1'b0;
        retire_valid = 1'b0;
        nuke         = 1'b0;
    endtask

    initial begin
        int   base;
        logic acc;
        void'($urandom(32'hef64_9bef));
        clk             = 0;
        rst             = 1;
        nuke            = 0;
        in_valid        = 0;
        in_uop          = '0;
        out_ready       = 1;
        wb_valid        = 0;
        wb_preg         = '0;
        retire_valid    = 0;
        retire_gpr      = '0;
        retire_pdst     = '0;
        retire_pdst_old = '0;
        n_checks        = 0;
        n_errors        = 0;
        cycles          = 0;
        ready_low_left  = 0;
        last_acc        = 0;
        test_name[1] = "basic renaming";
        test_name[2] = "pending bits";
        test_name[3] = "back-pressure";
        test_name[4] = "flush recovery";
        test_name[5] = "resource stall and reclaim";
        test_name[6] = "flush after retire";
        add_step(K_REN, 1, 1'b1, 1, 2, 3, 1'b0, 0, 0, 2);
        add_step(K_REN, 1, 1'b1, 2, 1, 1, 1'b0, 0, 0, 2);
        add_step(K_REN, 1, 1'b0, 0, 1, 2, 1'b0, 0, 0, 2);   // No destination.
        add_step(K_REN, 1, 1'b1, 1, 2, 4, 1'b0, 0, 0, 2);
        add_step(K_IDLE, 1, 1'b0, 0, 0, 0, 1'b0, 0, 3, 1);
        add_step(K_WB, 2, 1'b0, 0, 0, 0, 1'b1, 32, 0, 2);
        add_step(K_REN, 2, 1'b1, 5, 1, 2, 1'b0, 0, 0, 2);
        add_step(K_WB, 2, 1'b0, 0, 0, 0, 1'b1, 33, 0, 2);
        add_step(K_REN, 2, 1'b1, 6, 2, 1, 1'b0, 0, 0, 2);
        add_step(K_REN, 2, 1'b1, 7, 1, 5, 1'b1, 34, 0, 2);  // Writeback in the lookup cycle.
        add_step(K_IDLE, 2, 1'b0, 0, 0, 0, 1'b0, 0, 2, 1);
        add_step(K_STALL, 3, 1'b0, 0, 0, 0, 1'b0, 0, 0, 2);
        add_step(K_REN, 3, 1'b1, 11, 5, 6, 1'b0, 0, 0, 2);
        add_step(K_REN, 3, 1'b1, 12, 11, 7, 1'b0, 0, 0, 2);
        add_step(K_REN, 3, 1'b1, 13, 12, 11, 1'b0, 0, 0, 2);
        add_step(K_STALL, 3, 1'b0, 0, 0, 0, 1'b0, 0, 0, 2);
        add_step(K_REN, 3, 1'b1, 14, 13, 1, 1'b0, 0, 0, 2);
        add_step(K_REN, 3, 1'b0, 0, 14, 12, 1'b0, 0, 0, 2);
        add_step(K_IDLE, 3, 1'b0, 0, 0, 0, 1'b0, 0, 8, 2);
        add_step(K_STALL, 4, 1'b0, 0, 0, 0, 1'b0, 0, 0, 2);
        add_step(K_REN, 4, 1'b1, 3, 1, 2, 1'b0, 0, 0, 2);
        add_step(K_NUKE, 4, 1'b0, 0, 0, 0, 1'b0, 0, 0, 2);
        add_step(K_IDLE, 4, 1'b0, 0, 0, 0, 1'b0, 0, 2, 1);
        add_step(K_REN, 4, 1'b1, 8, 1, 7, 1'b0, 0, 0, 2);
        for (int k = 0; k < 15; k++) begin
            add_step(K_REN, 5, 1'b1, 10 + k, k, k + 1, 1'b0, 0, 0, 2);
        end
        add_step(K_IDLE, 5, 1'b0, 0, 0, 0, 1'b0, 0, 4, 0);  // ROB full.
        add_step(K_RET, 5, 1'b0, 0, 0, 0, 1'b0, 0, 0, 2);
        add_step(K_REN, 5, 1'b1, 9, 8, 3, 1'b0, 0, 0, 2);
        add_step(K_NUKE, 6, 1'b0, 0, 0, 0, 1'b0, 0, 0, 2);
        add_step(K_REN, 6, 1'b1, 10, 8, 9, 1'b0, 0, 0, 2);
        add_step(K_IDLE, 6, 1'b0, 0, 0, 0, 1'b0, 0, 4, 2);
        cycle_limit = 20 * st_kind.size() + 200;
        for (int g = 0; g < `RN_NUM_GPRS; g++) begin
            m_spec[g] = t_preg_id'(g);
            m_ret[g]  = t_preg_id'(g);
        end
        m_pend      = '0;
        m_inuse     = {{(`RN_NUM_PREGS-`RN_NUM_GPRS){1'b0}}, {`RN_NUM_GPRS{1'b1}}};
        m_free      = ~m_inuse;
        m_alloc_ptr = '0;
        m_ret_ptr   = '0;
        m_count     = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst  = 0;
        base = 0;
        for (int i = 0; i < st_kind.size(); i++) begin
            case (st_kind[i])
                K_REN: begin
                    in_valid = 1'b1;
                    in_uop   = st_uop[i];
                    acc      = 1'b0;
                    while (!acc) begin
                        wb_valid = st_wb_en[i];
                        wb_preg  = st_wb_preg[i];
                        tick(st_exp[i], acc);
                    end
                    in_valid = 1'b0;
                end
                K_WB: begin
                    wb_valid = 1'b1;
                    wb_preg  = st_wb_preg[i];
                    tick(2, acc);
                end
                K_RET: begin
                    if (rq_gpr.size() == 0) begin
                        n_errors++;
                        $display("error: retire step found no micro-op in flight");
                    end else begin
                        retire_valid    = 1'b1;
                        retire_gpr      = rq_gpr.pop_front();
                        retire_pdst     = rq_pdst.pop_front();
                        retire_pdst_old = rq_old.pop_front();
                        tick(2, acc);
                    end
                end
                K_STALL: ready_low_left = 2 + $urandom % 5;
                K_NUKE: begin
                    nuke = 1'b1;
                    tick(2, acc);
                end
                default: begin
                    repeat (st_n[i]) tick(st_exp[i], acc);
                end
            endcase
            if (i == st_kind.size() - 1 || st_test[i + 1] != st_test[i]) begin
                $display("test %0d (%s) finished with %0d errors", st_test[i],
                         test_name[st_test[i]], n_errors - base);
                base = n_errors;
            end
        end
        while (exp_q.size() > 0) begin
            tick(2, acc);
        end
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/rename_pkg.sv
rename/rename_map.sv
rename/rename_skid.sv
rename/rename_stage.sv
design/rob_credit.sv
design/rename_unit.sv
tests/rename_unit_tb.sv
